// File: Makefile
# Verilator build and run of the counter block testbench

VERILATOR ?= verilator
TOP       ?= tb_sync_counter_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: axi4lite_slave/axi4lite_slave.sv
`timescale 1ns/1ps

module axi4lite_slave #(
  parameter int addr_width = 11
) (
  input  logic                                 S_AXI_ACLK,
  input  logic                                 S_AXI_ARESETN,
  // Write address channel
  input  logic [addr_width-1:0]                awaddr,
  input  logic [2:0]                           awprot,
  input  logic                                 awvalid,
  output logic                                 awready,
  // Write data channel
  input  logic [counter_pkg::data_width-1:0]   wdata,
  input  logic [counter_pkg::data_width/8-1:0] wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  // Write response channel
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  // Read address channel
  input  logic [addr_width-1:0]                araddr,
  input  logic [2:0]                           arprot,
  input  logic                                 arvalid,
  output logic                                 arready,
  // Read data channel
  output logic [counter_pkg::data_width-1:0]   rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,
  // Register access
  reg_bus_if.master                            bus
);

  // Word index is everything above the byte offset
  localparam int idx_width = addr_width - 2;

  typedef enum logic {wr_idle, wr_resp} wr_state_e;
  typedef enum logic {rd_idle, rd_data} rd_state_e;

  wr_state_e             wr_state;
  rd_state_e             rd_state;
  logic                  aw_accept;
  logic                  ar_accept;
  logic [idx_width-1:0]  aw_word;
  logic [idx_width-1:0]  ar_word;
  logic                  aw_in_range;
  logic                  ar_in_range;
  logic [1:0]            bresp_q;
  logic [1:0]            rresp_q;
  logic [counter_pkg::data_width-1:0] rdata_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign aw_word     = awaddr[addr_width-1:2];
  assign ar_word     = araddr[addr_width-1:2];
  // Range check on the word index alone
  assign aw_in_range = aw_word < idx_width'(counter_pkg::reg_count);
  assign ar_in_range = ar_word < idx_width'(counter_pkg::reg_count);

  // Register access, write strobe only inside the map
  assign bus.wr_en    = aw_accept && aw_in_range;
  assign bus.wr_index = counter_pkg::reg_addr_e'(aw_word[2:0]);
  assign bus.wr_data  = wdata;
  assign bus.wr_strb  = wstrb;
  assign bus.rd_index = counter_pkg::reg_addr_e'(ar_word[2:0]);

  //////////////////////////////
  // Write path
  //////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_state  <= wr_idle;
      aw_accept <= 1'b0;
    end else begin
      case (wr_state)
        wr_idle: begin
          // Ready pulse for one cycle, then wait on the response
          if (aw_accept) begin
            aw_accept <= 1'b0;
            wr_state  <= wr_resp;
          end else if (awvalid && wvalid) begin
            aw_accept <= 1'b1;
          end
        end
        wr_resp: begin
          if (bready) begin
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // Response code latched with the accepted address
  always_ff @(posedge S_AXI_ACLK) begin
    if (aw_accept) begin
      bresp_q <= aw_in_range ? counter_pkg::resp_okay : counter_pkg::resp_slverr;
    end
  end

  assign awready = aw_accept;
  assign wready  = aw_accept;
  assign bvalid  = (wr_state == wr_resp);
  assign bresp   = bresp_q;

  //////////////////////////////
  // Read path
  //////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rd_state  <= rd_idle;
      ar_accept <= 1'b0;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (ar_accept) begin
            ar_accept <= 1'b0;
            rd_state  <= rd_data;
          end else if (arvalid) begin
            ar_accept <= 1'b1;
          end
        end
        rd_data: begin
          if (rready) begin
            rd_state <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  // Data and response captured in the ready cycle
  always_ff @(posedge S_AXI_ACLK) begin
    if (ar_accept) begin
      rdata_q <= ar_in_range ? bus.rd_data : '0;
      rresp_q <= ar_in_range ? counter_pkg::resp_okay : counter_pkg::resp_slverr;
    end
  end

  assign arready = ar_accept;
  assign rvalid  = (rd_state == rd_data);
  assign rdata   = rdata_q;
  assign rresp   = rresp_q;

  // Responses are held until the master takes them
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid && !bready |=> bvalid && $stable(bresp));
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: bench/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

//////////////////////////////
// Compare and report
//////////////////////////////

// Stops the run at the first mismatch
task automatic check(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
  if (actual !== expected) begin
    $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopping at first mismatch");
  end
endtask

//////////////////////////////
// AXI4-Lite master
//////////////////////////////

// One write, BREADY held low for bready_delay cycles once BVALID is up
task automatic axi_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input int bready_delay,
                         output logic [1:0] resp);
  @(negedge S_AXI_ACLK);
  s_axi_awaddr  = addr;
  s_axi_wdata   = data;
  s_axi_wstrb   = strb;
  s_axi_awvalid = 1'b1;
  s_axi_wvalid  = 1'b1;
  s_axi_bready  = 1'b0;
  // Ready pulse shows up one cycle after both valids
  @(negedge S_AXI_ACLK);
  while (!s_axi_awready) @(negedge S_AXI_ACLK);
  check("axi_write wready with awready", 32'd1, 32'(s_axi_wready));
  // Handshake edge passes, then drop the valids
  @(negedge S_AXI_ACLK);
  s_axi_awvalid = 1'b0;
  s_axi_wvalid  = 1'b0;
  check("axi_write bvalid after handshake", 32'd1, 32'(s_axi_bvalid));
  // Response must wait for the master
  repeat (bready_delay) begin
    @(negedge S_AXI_ACLK);
    check("axi_write bvalid held", 32'd1, 32'(s_axi_bvalid));
  end
  resp = s_axi_bresp;
  s_axi_bready = 1'b1;
  @(negedge S_AXI_ACLK);
  s_axi_bready = 1'b0;
endtask

// One read, data and response taken while RVALID is high
task automatic axi_read(input logic [addr_width-1:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
  @(negedge S_AXI_ACLK);
  s_axi_araddr  = addr;
  s_axi_arvalid = 1'b1;
  s_axi_rready  = 1'b0;
  @(negedge S_AXI_ACLK);
  while (!s_axi_arready) @(negedge S_AXI_ACLK);
  @(negedge S_AXI_ACLK);
  s_axi_arvalid = 1'b0;
  check("axi_read rvalid after handshake", 32'd1, 32'(s_axi_rvalid));
  data = s_axi_rdata;
  resp = s_axi_rresp;
  s_axi_rready = 1'b1;
  @(negedge S_AXI_ACLK);
  s_axi_rready = 1'b0;
endtask

//////////////////////////////
// Test clock side
//////////////////////////////

// Enable high for exactly cycles rising edges of tclk
task automatic pulse_enable(input logic use_b, input int cycles);
  @(negedge tclk);
  if (use_b) begin
    enable_b = 1'b1;
  end else begin
    enable_a = 1'b1;
  end
  repeat (cycles) @(negedge tclk);
  enable_a = 1'b0;
  enable_b = 1'b0;
endtask

`endif

// File: bench/tb_sync_counter_top.sv
`timescale 1ns/1ps

module tb_sync_counter_top;

  localparam int addr_width     = 11;
  // Build values of the DUT at its defaults
  localparam int counter_a_bits = 32;
  localparam int offset_a_bits  = 0;
  localparam int counter_b_bits = 16;
  localparam int offset_b_bits  = 4;
  // Directed tests in this run, sets the watchdog limit
  localparam int test_count     = 5;

  logic                  S_AXI_ACLK = 1'b0;
  logic                  S_AXI_ARESETN;
  logic                  tclk = 1'b0;
  logic                  enable_a;
  logic                  enable_b;
  logic [addr_width-1:0] s_axi_awaddr;
  logic [2:0]            s_axi_awprot;
  logic                  s_axi_awvalid;
  logic                  s_axi_awready;
  logic [31:0]           s_axi_wdata;
  logic [3:0]            s_axi_wstrb;
  logic                  s_axi_wvalid;
  logic                  s_axi_wready;
  logic [1:0]            s_axi_bresp;
  logic                  s_axi_bvalid;
  logic                  s_axi_bready;
  logic [addr_width-1:0] s_axi_araddr;
  logic [2:0]            s_axi_arprot;
  logic                  s_axi_arvalid;
  logic                  s_axi_arready;
  logic [31:0]           s_axi_rdata;
  logic [1:0]            s_axi_rresp;
  logic                  s_axi_rvalid;
  logic                  s_axi_rready;
  // Running total of counter A since its last clear
  longint                a_total;

  `include "tb_axi_tasks.svh"

  // Bus clock 20 ns, test clock 14 ns
  always #10 S_AXI_ACLK = ~S_AXI_ACLK;
  always #7 tclk = ~tclk;

  sync_counter_top u_sync_counter_top (
    .S_AXI_ACLK    (S_AXI_ACLK),    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),  .s_axi_awprot  (s_axi_awprot),
    .s_axi_awvalid (s_axi_awvalid), .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),   .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),  .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),   .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),  .s_axi_araddr  (s_axi_araddr),
    .s_axi_arprot  (s_axi_arprot),  .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready), .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),   .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),  .tclk          (tclk),
    .enable_a      (enable_a),      .enable_b      (enable_b)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Byte address of a word index
  function automatic logic [addr_width-1:0] word_addr(input int index);
    return addr_width'(index * 4);
  endfunction

  // Count seen through the offset, kept to the counter width
  function automatic logic [31:0] scaled_count(input longint count, input int bits,
                                               input int offset);
    return 32'((count >> offset) % (longint'(1) << bits));
  endfunction

  task automatic read_expect(input string name, input int index, input logic [31:0] expected);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(word_addr(index), data, resp);
    check({name, " data"}, expected, data);
    check({name, " resp"}, 32'(counter_pkg::resp_okay), 32'(resp));
  endtask

  task automatic write_expect(input string name, input int index, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(word_addr(index), data, 4'hf, 0, resp);
    check({name, " bresp"}, 32'(counter_pkg::resp_okay), 32'(resp));
  endtask

  // Falling then rising snapshot bit, then room for the crossing
  task automatic snapshot();
    write_expect("snapshot clear", counter_pkg::reg_snapshot, 32'h0);
    write_expect("snapshot set", counter_pkg::reg_snapshot, 32'h1);
    repeat (10) @(posedge tclk);
    repeat (10) @(negedge S_AXI_ACLK);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic reset_values();
    logic [31:0] expected [8];
    expected = '{0, 0, 0, 0, counter_a_bits, offset_a_bits, counter_b_bits, offset_b_bits};
    for (int i = 0; i < counter_pkg::reg_count; i++) begin
      read_expect($sformatf("reset_values word %0d", i), i, expected[i]);
    end
  endtask

  task automatic count_a();
    int n;
    int m;
    n = 1 + int'($urandom % 300);
    m = 1 + int'($urandom % 300);
    pulse_enable(1'b0, n);
    snapshot();
    read_expect("count_a first result_a", counter_pkg::reg_result_a,
                scaled_count(n, counter_a_bits, offset_a_bits));
    read_expect("count_a first result_b", counter_pkg::reg_result_b, 32'd0);
    // Second burst adds on top of the first
    pulse_enable(1'b0, m);
    snapshot();
    a_total = n + m;
    read_expect("count_a second result_a", counter_pkg::reg_result_a,
                scaled_count(a_total, counter_a_bits, offset_a_bits));
  endtask

  task automatic scaled_b();
    int n;
    n = 1 + int'($urandom % 2000);
    pulse_enable(1'b1, n);
    snapshot();
    read_expect("scaled_b result_b", counter_pkg::reg_result_b,
                scaled_count(n, counter_b_bits, offset_b_bits));
    read_expect("scaled_b result_a", counter_pkg::reg_result_a,
                scaled_count(a_total, counter_a_bits, offset_a_bits));
  endtask

  task automatic reset_hold();
    write_expect("reset_hold set", counter_pkg::reg_reset, 32'h1);
    read_expect("reset_hold bit", counter_pkg::reg_reset, 32'h1);
    // Clear reaches tclk through the synchronizer
    repeat (4) @(negedge tclk);
    pulse_enable(1'b0, 25);
    pulse_enable(1'b1, 40);
    write_expect("reset_hold release", counter_pkg::reg_reset, 32'h0);
    snapshot();
    read_expect("reset_hold result_a", counter_pkg::reg_result_a, 32'd0);
    read_expect("reset_hold result_b", counter_pkg::reg_result_b, 32'd0);
  endtask

  task automatic bus_rules();
    logic [31:0] data;
    logic [1:0]  resp;
    // Partial strobe is answered but ignored
    axi_write(word_addr(counter_pkg::reg_reset), 32'h1, 4'b0111, 0, resp);
    check("bus_rules partial bresp", 32'(counter_pkg::resp_okay), 32'(resp));
    read_expect("bus_rules partial", counter_pkg::reg_reset, 32'h0);
    write_expect("bus_rules param write", counter_pkg::reg_param_counter_b, 32'hffff_ffff);
    read_expect("bus_rules param", counter_pkg::reg_param_counter_b, counter_b_bits);
    // First word past the map, its low index bits match the reset word
    axi_write(word_addr(counter_pkg::reg_count), 32'h1, 4'hf, 0, resp);
    check("bus_rules range bresp", 32'(counter_pkg::resp_slverr), 32'(resp));
    read_expect("bus_rules range write ignored", counter_pkg::reg_reset, 32'h0);
    // Reset bit high so a read leaking through the alias would not be zero
    write_expect("bus_rules alias set", counter_pkg::reg_reset, 32'h1);
    axi_read(word_addr(counter_pkg::reg_count), data, resp);
    check("bus_rules range rresp", 32'(counter_pkg::resp_slverr), 32'(resp));
    check("bus_rules range rdata", 32'd0, data);
    write_expect("bus_rules alias clear", counter_pkg::reg_reset, 32'h0);
    // Slow master on the response channel
    axi_write(word_addr(counter_pkg::reg_snapshot), 32'h0, 4'hf, 5, resp);
    check("bus_rules bready delay", 32'(counter_pkg::resp_okay), 32'(resp));
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////

  initial begin
    #(test_count * 50_000);
    $display("Watchdog: run did not finish within %0d us", test_count * 50);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Watchdog timeout");
  end

  initial begin
    void'($urandom(32'hd993_a6df));
    S_AXI_ARESETN = 1'b0;
    enable_a      = 1'b0;
    enable_b      = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awprot  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arprot  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    a_total       = 0;
    repeat (5) @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    // tclk side leaves reset a little later
    repeat (4) @(negedge tclk);
    reset_values();
    count_a();
    scaled_b();
    reset_hold();
    bus_rules();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: common/counter_pkg.sv
package counter_pkg;

  //////////////////////////////
  // Bus geometry
  //////////////////////////////

  // Register and bus data width, fixed for the whole block
  localparam int data_width = 32;

  // Number of 32-bit words in the register map
  localparam int reg_count = 8;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Word index of each register, byte address is index times four
  typedef enum logic [2:0] {
    // Control bits, bit 0 only
    reg_reset           = 3'd0,
    reg_snapshot        = 3'd1,
    // Captured counter values
    reg_result_a        = 3'd2,
    reg_result_b        = 3'd3,
    // Read-only build parameters
    reg_param_counter_a = 3'd4,
    reg_param_offset_a  = 3'd5,
    reg_param_counter_b = 3'd6,
    reg_param_offset_b  = 3'd7
  } reg_addr_e;

  //////////////////////////////
  // Response codes
  //////////////////////////////

  // AXI OKAY
  localparam logic [1:0] resp_okay = 2'b00;

  // AXI SLVERR, used for an index outside the map
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: common/reg_bus_if.sv
`timescale 1ns/1ps

// Register access path between the bus slave and the register map
interface reg_bus_if;

  // Single-cycle write pulse, only for an index inside the map
  logic                                   wr_en;
  counter_pkg::reg_addr_e                 wr_index;
  logic [counter_pkg::data_width-1:0]     wr_data;
  logic [counter_pkg::data_width/8-1:0]   wr_strb;

  // Read side, rd_data follows rd_index with no register in between
  counter_pkg::reg_addr_e                 rd_index;
  logic [counter_pkg::data_width-1:0]     rd_data;

  // Bus slave side
  modport master (
    output wr_en, wr_index, wr_data, wr_strb, rd_index,
    input  rd_data
  );

  // Register map side
  modport target (
    input  wr_en, wr_index, wr_data, wr_strb, rd_index,
    output rd_data
  );

endinterface

// File: hw/sync_counter_regs.sv
`timescale 1ns/1ps

module sync_counter_regs #(
  parameter int counter_a_bits = 32,
  parameter int offset_a_bits  = 0,
  parameter int counter_b_bits = 16,
  parameter int offset_b_bits  = 4
) (
  input  logic                               S_AXI_ACLK,
  input  logic                               S_AXI_ARESETN,
  reg_bus_if.target                          bus,
  output logic                               reset_req,
  output logic                               snapshot_req,
  input  logic [counter_pkg::data_width-1:0] result_a,
  input  logic [counter_pkg::data_width-1:0] result_b
);

  localparam int dw = counter_pkg::data_width;

  logic                 full_strobe;
  logic [dw-1:0]        rd_words [counter_pkg::reg_count];

  //////////////////////////////
  // Control bits
  //////////////////////////////

  // Only whole-word writes touch the control bits
  assign full_strobe = &bus.wr_strb;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      reset_req    <= 1'b0;
      snapshot_req <= 1'b0;
    end else if (bus.wr_en && full_strobe) begin
      case (bus.wr_index)
        counter_pkg::reg_reset:    reset_req    <= bus.wr_data[0];
        counter_pkg::reg_snapshot: snapshot_req <= bus.wr_data[0];
        // Results and parameters are read-only
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Read data
  //////////////////////////////

  always_comb begin
    rd_words[counter_pkg::reg_reset]           = dw'(reset_req);
    rd_words[counter_pkg::reg_snapshot]        = dw'(snapshot_req);
    // Already in the bus clock domain
    rd_words[counter_pkg::reg_result_a]        = result_a;
    rd_words[counter_pkg::reg_result_b]        = result_b;
    // Build parameters, fixed at elaboration
    rd_words[counter_pkg::reg_param_counter_a] = dw'(counter_a_bits);
    rd_words[counter_pkg::reg_param_offset_a]  = dw'(offset_a_bits);
    rd_words[counter_pkg::reg_param_counter_b] = dw'(counter_b_bits);
    rd_words[counter_pkg::reg_param_offset_b]  = dw'(offset_b_bits);
  end

  assign bus.rd_data = rd_words[bus.rd_index];

endmodule

// File: hw/sync_counter_top.sv
`timescale 1ns/1ps

module sync_counter_top #(
  parameter int counter_a_bits = 32,
  parameter int offset_a_bits  = 0,
  parameter int counter_b_bits = 16,
  parameter int offset_b_bits  = 4,
  parameter int addr_width     = 11
) (
  input  logic                                 S_AXI_ACLK,
  input  logic                                 S_AXI_ARESETN,
  // AXI4-Lite write channels
  input  logic [addr_width-1:0]                s_axi_awaddr,
  input  logic [2:0]                           s_axi_awprot,
  input  logic                                 s_axi_awvalid,
  output logic                                 s_axi_awready,
  input  logic [counter_pkg::data_width-1:0]   s_axi_wdata,
  input  logic [counter_pkg::data_width/8-1:0] s_axi_wstrb,
  input  logic                                 s_axi_wvalid,
  output logic                                 s_axi_wready,
  output logic [1:0]                           s_axi_bresp,
  output logic                                 s_axi_bvalid,
  input  logic                                 s_axi_bready,
  // AXI4-Lite read channels
  input  logic [addr_width-1:0]                s_axi_araddr,
  input  logic [2:0]                           s_axi_arprot,
  input  logic                                 s_axi_arvalid,
  output logic                                 s_axi_arready,
  output logic [counter_pkg::data_width-1:0]   s_axi_rdata,
  output logic [1:0]                           s_axi_rresp,
  output logic                                 s_axi_rvalid,
  input  logic                                 s_axi_rready,
  // Test clock domain
  input  logic                                 tclk,
  input  logic                                 enable_a,
  input  logic                                 enable_b
);

  logic                               reset_req;
  logic                               snapshot_req;
  logic [counter_pkg::data_width-1:0] result_a;
  logic [counter_pkg::data_width-1:0] result_b;

  reg_bus_if u_reg_bus ();

  ////////////////////////////////
  // Bus front end
  ////////////////////////////////

  axi4lite_slave #(
    .addr_width (addr_width)
  ) u_axi4lite_slave (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (s_axi_awaddr),
    .awprot        (s_axi_awprot),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bresp         (s_axi_bresp),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .araddr        (s_axi_araddr),
    .arprot        (s_axi_arprot),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .bus           (u_reg_bus.master)
  );

  // Control and status words
  sync_counter_regs #(
    .counter_a_bits (counter_a_bits),
    .offset_a_bits  (offset_a_bits),
    .counter_b_bits (counter_b_bits),
    .offset_b_bits  (offset_b_bits)
  ) u_sync_counter_regs (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .bus           (u_reg_bus.target),
    .reset_req     (reset_req),
    .snapshot_req  (snapshot_req),
    .result_a      (result_a),
    .result_b      (result_b)
  );

  ////////////////////////////////
  // Counter core
  ////////////////////////////////

  sync_counter #(
    .counter_a_bits (counter_a_bits),
    .offset_a_bits  (offset_a_bits),
    .counter_b_bits (counter_b_bits),
    .offset_b_bits  (offset_b_bits)
  ) u_sync_counter (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .tclk          (tclk),
    .enable_a      (enable_a),
    .enable_b      (enable_b),
    .reset_req     (reset_req),
    .snapshot_req  (snapshot_req),
    .result_a      (result_a),
    .result_b      (result_b)
  );

endmodule

// File: project.f
+incdir+bench
common/counter_pkg.sv
common/reg_bus_if.sv
axi4lite_slave/axi4lite_slave.sv
sync_counter/counter_channel.sv
sync_counter/sync_counter.sv
hw/sync_counter_regs.sv
hw/sync_counter_top.sv
bench/tb_sync_counter_top.sv

// File: sync_counter/counter_channel.sv
`timescale 1ns/1ps

module counter_channel #(
  parameter int counter_bits = 32,
  parameter int offset_bits  = 0
) (
  input  logic        tclk,
  input  logic        clear,
  input  logic        enable,
  input  logic        capture,
  output logic [31:0] captured
);

  // Low offset bits act as a prescaler below the reported count
  localparam int total_bits = counter_bits + offset_bits;

  logic [total_bits-1:0] count;

  // Free count of enabled cycles, wraps at full width
  always_ff @(posedge tclk) begin
    if (clear) begin
      count <= '0;
    end else if (enable) begin
      count <= count + 1'b1;
    end
  end

  // Upper bits only, zero-extended to the bus width
  always_ff @(posedge tclk) begin
    if (capture) begin
      captured <= 32'(count[total_bits-1:offset_bits]);
    end
  end

  // Clear wins over enable
  assert property (@(posedge tclk) clear |=> (count == '0));

endmodule

// File: sync_counter/sync_counter.sv
`timescale 1ns/1ps

module sync_counter #(
  parameter int counter_a_bits = 32,
  parameter int offset_a_bits  = 0,
  parameter int counter_b_bits = 16,
  parameter int offset_b_bits  = 4
) (
  input  logic        S_AXI_ACLK,
  input  logic        S_AXI_ARESETN,
  input  logic        tclk,
  input  logic        enable_a,
  input  logic        enable_b,
  input  logic        reset_req,
  input  logic        snapshot_req,
  output logic [31:0] result_a,
  output logic [31:0] result_b
);

  logic [1:0]  aresetn_sync;
  logic        tclk_rst;
  logic [1:0]  reset_sync;
  logic [2:0]  snap_sync;
  logic        snap_rise;
  logic        clear;
  logic        done_toggle;
  logic [31:0] captured_a;
  logic [31:0] captured_b;
  logic [2:0]  done_sync;
  logic        done_edge;

  //////////////////////////////
  // Test clock domain
  //////////////////////////////

  // Bus reset brought into tclk, used as a synchronous reset
  always_ff @(posedge tclk) begin
    aresetn_sync <= {aresetn_sync[0], S_AXI_ARESETN};
  end
  assign tclk_rst = ~aresetn_sync[1];

  // Two-flop sync of both control bits, third snapshot flop for the edge
  always_ff @(posedge tclk) begin
    if (tclk_rst) begin
      reset_sync  <= '0;
      snap_sync   <= '0;
      done_toggle <= 1'b0;
    end else begin
      reset_sync <= {reset_sync[0], reset_req};
      snap_sync  <= {snap_sync[1:0], snapshot_req};
      // One flip per captured pair
      if (snap_rise) begin
        done_toggle <= ~done_toggle;
      end
    end
  end

  assign snap_rise = snap_sync[1] & ~snap_sync[2];
  assign clear     = tclk_rst | reset_sync[1];

  counter_channel #(
    .counter_bits (counter_a_bits),
    .offset_bits  (offset_a_bits)
  ) u_channel_a (
    .tclk     (tclk),
    .clear    (clear),
    .enable   (enable_a),
    .capture  (snap_rise),
    .captured (captured_a)
  );

  counter_channel #(
    .counter_bits (counter_b_bits),
    .offset_bits  (offset_b_bits)
  ) u_channel_b (
    .tclk     (tclk),
    .clear    (clear),
    .enable   (enable_b),
    .capture  (snap_rise),
    .captured (captured_b)
  );

  //////////////////////////////
  // Bus clock domain
  //////////////////////////////

  // Capture registers are quiet by the time the toggle lands here
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      done_sync <= '0;
      result_a  <= '0;
      result_b  <= '0;
    end else begin
      done_sync <= {done_sync[1:0], done_toggle};
      if (done_edge) begin
        result_a <= captured_a;
        result_b <= captured_b;
      end
    end
  end

  assign done_edge = done_sync[2] ^ done_sync[1];

  // Results only move with a returned snapshot
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    !done_edge |=> $stable(result_a) && $stable(result_b));

endmodule
